// File: tx_patterns.txt
// mode body_len tail_len body_num intr_width stop_frame dma_density(of 8) abort_cycles
// all values hex, one test case per line
0 0040 0020 0003 0005 0000 0008 0000
0 0010 0008 0002 000A 0000 0001 0000
1 0020 0000 0000 0000 0003 0008 0000
0 0080 0040 0004 0003 0000 0008 0030
0 0018 0010 0001 0001 0000 0003 0000
0 0040 0040 0000 0004 0000 0008 0000
1 0010 0000 0000 0000 0001 0008 0000
0 0008 0008 0005 0002 0000 0002 0000

// File: verilog.f
tlk_line_pkg.sv
tx_ctrl_pkg.sv
tx_word_fifo.sv
tx_frame_fsm.sv
tx_line_encoder.sv
tlk2711_tx.sv
tb_tlk2711_tx.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module tb_tlk2711_tx -o sim_tb
	-./obj_dir/sim_tb 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_tlk2711_tx.sv
// testbench for the TLK2711 transmit framer, pattern-file driven with frame parser and checks
`timescale 1ns/1ps

module tb_tlk2711_tx;

    localparam int SYNC_W = 4;
    localparam int GAP_W  = 5;
    localparam int BEATS  = 8;
    localparam int NCOL   = 8;
    localparam int MAXC   = 16;

    localparam tlk_line_pkg::line_out_t COMMA = '{txd: 16'hC5BC, tk_msb: 1'b0, tk_lsb: 1'b1};
    localparam tlk_line_pkg::line_out_t SOF   = '{txd: 16'h5CFB, tk_msb: 1'b1, tk_lsb: 1'b1};
    localparam tlk_line_pkg::line_out_t EOF   = '{txd: 16'hFDFE, tk_msb: 1'b1, tk_lsb: 1'b1};

    logic                         clk;
    logic                         soft_reset;
    logic                         tx_start;
    logic                         stop_test;
    tx_ctrl_pkg::tx_mode_e        tx_mode;
    tx_ctrl_pkg::byte_len_t       body_len;
    tx_ctrl_pkg::byte_len_t       tail_len;
    tx_ctrl_pkg::frame_num_t      body_num;
    tx_ctrl_pkg::intr_width_t     intr_width;
    logic                         dma_valid;
    logic [63:0]                  dma_data;
    logic                         dma_ready;
    logic                         tx_intr;
    tlk_line_pkg::line_word_t     txd;
    logic                         tkmsb;
    logic                         tklsb;

    logic [15:0]                  pat [MAXC*NCOL];
    logic [31:0]                  rng;
    int                           cycles;
    int                           limit;
    int                           beats_left;
    int                           accepted;
    int                           first_beat;
    int                           pay_words;
    int                           den;
    tlk_line_pkg::line_out_t      cur;
    logic                         cur_intr;
    logic                         intr_ok;
    logic                         stop_req;
    logic                         will_take;
    tlk_line_pkg::line_word_t     exp_q [$];

    tlk2711_tx #(
        .DMA_WIDTH  (64),
        .FIFO_BEATS (BEATS),
        .SYNC_WORDS (SYNC_W),
        .GAP_WORDS  (GAP_W)
    ) u_tlk2711_tx (
        .clk              (clk),
        .i_soft_reset     (soft_reset),
        .i_tx_start       (tx_start),
        .i_stop_test      (stop_test),
        .i_tx_mode        (tx_mode),
        .i_tx_packet_body (body_len),
        .i_tx_packet_tail (tail_len),
        .i_tx_body_num    (body_num),
        .i_tx_intr_width  (intr_width),
        .i_dma_rd_valid   (dma_valid),
        .i_dma_rd_data    (dma_data),
        .o_dma_rd_ready   (dma_ready),
        .o_tx_interrupt   (tx_intr),
        .o_2711_txd       (txd),
        .o_2711_tkmsb     (tkmsb),
        .o_2711_tklsb     (tklsb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_line(input string name, input tlk_line_pkg::line_out_t got,
                              input tlk_line_pkg::line_out_t exp);
        if (got !== exp) begin
            report_error($sformatf("ERR %0t o_2711_txd/tkmsb/tklsb %s got %h exp %h",
                                   $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input tlk_line_pkg::line_word_t got,
                              input tlk_line_pkg::line_word_t exp);
        if (got !== exp) begin
            report_error($sformatf("ERR %0t o_2711_txd %s got %h exp %h",
                                   $time, name, got, exp));
        end
    endtask

    task automatic check_intr_width(input tx_ctrl_pkg::intr_width_t got,
                                    input tx_ctrl_pkg::intr_width_t exp);
        if (got !== exp) begin
            report_error($sformatf("ERR %0t o_tx_interrupt width got %0d exp %0d",
                                   $time, got, exp));
        end
    endtask

    // drives the DMA side once per falling edge
    task automatic dma_step();
        logic hold;
        hold = dma_valid && !will_take;
        if (will_take) begin
            if (accepted == 0) begin
                first_beat = cycles;
            end
            accepted++;
            beats_left--;
            for (int l = 0; l < 4; l++) begin
                exp_q.push_back(dma_data[l*16 +: 16]);
            end
        end
        if (!dma_ready && (accepted - pay_words / 4) < BEATS) begin
            report_error("o_dma_rd_ready is low while the FIFO is not full");
        end
        if (!hold) begin
            if (beats_left > 0 && (next_rand() % 8) < den) begin
                dma_valid = 1'b1;
                dma_data  = {next_rand(), next_rand()};
            end else begin
                dma_valid = 1'b0;
            end
        end
        will_take = dma_valid && dma_ready;
    endtask

    // samples one line word per falling edge and drives the inputs after it
    task automatic next_word();
        @(negedge clk);
        cycles++;
        if (cycles > limit) begin
            report_error("timeout, the framer stopped producing the expected words");
        end
        cur      = '{txd: txd, tk_msb: tkmsb, tk_lsb: tklsb};
        cur_intr = tx_intr;
        if (cur_intr && !intr_ok) begin
            report_error("interrupt raised outside the end of a file");
        end
        dma_step();
        stop_test = stop_req;
        stop_req  = 1'b0;
    endtask

    task automatic expect_data(input string name, input tlk_line_pkg::line_word_t w);
        next_word();
        check_line(name, cur, '{txd: w, tk_msb: 1'b0, tk_lsb: 1'b0});
    endtask

    //////////////////////////////
    // one test case
    //////////////////////////////

    task automatic run_case(input int c);
        int b;
        int f;
        int n;
        int got;
        int stop_at;
        int abort_at;
        int start_cyc;
        int sync_exp;
        int w;
        logic test;
        logic last;
        tx_ctrl_pkg::byte_len_t len;
        tlk_line_pkg::line_word_t sum;
        tlk_line_pkg::line_word_t exp;
        b          = c * NCOL;
        test       = pat[b][0];
        tx_mode    = tx_ctrl_pkg::tx_mode_e'(pat[b][0]);
        body_len   = pat[b+1];
        tail_len   = pat[b+2];
        body_num   = 24'(pat[b+3]);
        intr_width = pat[b+4];
        stop_at    = pat[b+5];
        den        = pat[b+6];
        abort_at   = pat[b+7];
        accepted   = 0;
        pay_words  = 0;
        beats_left = test ? 0 : (int'(body_num) * body_len + tail_len) / 8;
        tx_start   = 1'b1;
        next_word();
        tx_start   = 1'b0;
        start_cyc  = cycles;
        if (abort_at != 0) begin
            repeat (abort_at) next_word();
            soft_reset = 1'b1;
            beats_left = 0;
            dma_valid  = 1'b0;
            will_take  = 1'b0;
            exp_q.delete();
            repeat (3) next_word();
            check_line("reset line", cur, COMMA);
            soft_reset = 1'b0;
            repeat (4) begin
                next_word();
                check_line("line after reset", cur, COMMA);
            end
            return;
        end
        n = 0;
        while (cur === COMMA) begin
            n++;
            next_word();
        end
        // two commas pass before the sync words, plus any wait for the first DMA beat
        sync_exp = test ? SYNC_W + 2 : SYNC_W + 2 + (first_beat - start_cyc);
        if (n != sync_exp) begin
            report_error($sformatf("wrong comma count before the first SOF, got %0d expected %0d",
                                   n, sync_exp));
        end
        check_line("sof", cur, SOF);
        f = 0;
        forever begin
            last = !test && (f == int'(body_num));
            len  = last ? tail_len : body_len;
            if (f > 0) begin
                next_word();
                check_line("sof", cur, SOF);
            end
            if (test && f == stop_at) begin
                stop_req = 1'b1;
            end
            expect_data("head_0", 16'hEB90);
            expect_data("head_1", 16'hE116);
            expect_data("file sign", (test || last) ? 16'h8101 : 16'h8100);
            expect_data("frame number", 16'(f));
            expect_data("length", len);
            sum = 16'(f) + len;
            got = 0;
            while (got < len / 2) begin
                next_word();
                if (cur === COMMA && !test) begin
                    continue;
                end
                if (test) begin
                    exp = 16'(got);
                end else begin
                    if (exp_q.size() == 0) begin
                        report_error("payload word sent before its DMA beat was accepted");
                    end
                    exp = exp_q.pop_front();
                    pay_words++;
                end
                check_word("payload", cur.txd, exp);
                if (cur.tk_msb || cur.tk_lsb) begin
                    report_error("payload word carries a K flag");
                end
                sum = sum + exp;
                got++;
            end
            expect_data("checksum", sum);
            next_word();
            check_line("eof", cur, EOF);
            for (int g = 0; g < GAP_W; g++) begin
                if (last && g == GAP_W - 1) begin
                    intr_ok = 1'b1;
                end
                next_word();
                check_line("gap", cur, COMMA);
            end
            if (last) begin
                w = 0;
                while (cur_intr) begin
                    w++;
                    next_word();
                    check_line("idle", cur, COMMA);
                end
                check_intr_width(16'(w), intr_width);
                intr_ok = 1'b0;
                break;
            end
            if (test && f == stop_at) begin
                repeat (3 * GAP_W) begin
                    next_word();
                    check_line("after stop", cur, COMMA);
                end
                break;
            end
            f++;
        end
        if (exp_q.size() != 0 || beats_left != 0) begin
            report_error("DMA data left over after the file");
        end
    endtask

    initial begin
        int c;
        int frames;
        int len;
        soft_reset = 1'b1;
        tx_start   = 1'b0;
        stop_test  = 1'b0;
        tx_mode    = tx_ctrl_pkg::MODE_NORM;
        body_len   = '0;
        tail_len   = '0;
        body_num   = '0;
        intr_width = '0;
        dma_valid  = 1'b0;
        dma_data   = '0;
        rng        = 32'd42533;
        cycles     = 0;
        beats_left = 0;
        accepted   = 0;
        first_beat = 0;
        pay_words  = 0;
        den        = 0;
        intr_ok    = 1'b0;
        stop_req   = 1'b0;
        will_take  = 1'b0;
        for (int i = 0; i < MAXC * NCOL; i++) begin
            pat[i] = 16'hFFFF;
        end
        $readmemh("tx_patterns.txt", pat);
        // every word may be slowed by the DMA, with a margin per case
        limit = 200;
        for (c = 0; c < MAXC && pat[c*NCOL] != 16'hFFFF; c++) begin
            frames = pat[c*NCOL][0] ? pat[c*NCOL+5] + 2 : pat[c*NCOL+3] + 1;
            len    = (pat[c*NCOL+1] > pat[c*NCOL+2]) ? pat[c*NCOL+1] : pat[c*NCOL+2];
            limit += (SYNC_W + frames * (len / 2 + 9 + GAP_W)) * 8;
            limit += pat[c*NCOL+4] + pat[c*NCOL+7] + 100;
        end
        repeat (10) @(negedge clk);
        soft_reset = 1'b0;
        for (c = 0; c < MAXC && pat[c*NCOL] != 16'hFFFF; c++) begin
            repeat (4) begin
                next_word();
                check_line("idle", cur, COMMA);
            end
            run_case(c);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: tlk2711_tx.sv
// TLK2711 transmit framer top with mode latch, start flag and configuration packing
`timescale 1ns/1ps

module tlk2711_tx #(
    parameter int DMA_WIDTH  = 64,
    parameter int FIFO_BEATS = 64,
    parameter int SYNC_WORDS = 6,
    parameter int GAP_WORDS  = 16
) (
    input  logic                        clk,
    input  logic                        i_soft_reset,
    input  logic                        i_tx_start,
    input  logic                        i_stop_test,
    input  tx_ctrl_pkg::tx_mode_e       i_tx_mode,
    input  tx_ctrl_pkg::byte_len_t      i_tx_packet_body,
    input  tx_ctrl_pkg::byte_len_t      i_tx_packet_tail,
    input  tx_ctrl_pkg::frame_num_t     i_tx_body_num,
    input  tx_ctrl_pkg::intr_width_t    i_tx_intr_width,
    input  logic                        i_dma_rd_valid,
    input  logic [DMA_WIDTH-1:0]        i_dma_rd_data,
    output logic                        o_dma_rd_ready,
    output logic                        o_tx_interrupt,
    output tlk_line_pkg::line_word_t    o_2711_txd,
    output logic                        o_2711_tkmsb,
    output logic                        o_2711_tklsb
);

    tx_ctrl_pkg::tx_mode_e    mode;
    tx_ctrl_pkg::frame_cfg_t  cfg;
    tx_ctrl_pkg::word_kind_e  kind;
    tlk_line_pkg::line_word_t fifo_word;
    tlk_line_pkg::line_out_t  fsm_line;
    tlk_line_pkg::line_out_t  enc_line;
    logic                     start_flag;
    logic                     fifo_avail;
    logic                     word_take;
    logic                     frame_begun;
    logic                     sum_clear;

    // mode is taken with the start pulse, flag stays up until the sequencer starts
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            mode       <= tx_ctrl_pkg::MODE_NORM;
            start_flag <= 1'b0;
        end else if (i_tx_start) begin
            mode       <= i_tx_mode;
            start_flag <= 1'b1;
        end else if (frame_begun) begin
            start_flag <= 1'b0;
        end
    end

    assign cfg = '{body_len:   i_tx_packet_body,
                   tail_len:   i_tx_packet_tail,
                   body_num:   i_tx_body_num,
                   intr_width: i_tx_intr_width};

    tx_word_fifo #(
        .DMA_WIDTH  (DMA_WIDTH),
        .FIFO_BEATS (FIFO_BEATS)
    ) u_tx_word_fifo (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_wr_valid   (i_dma_rd_valid),
        .i_wr_data    (i_dma_rd_data),
        .o_wr_ready   (o_dma_rd_ready),
        .i_word_take  (word_take),
        .o_word       (fifo_word),
        .o_word_avail (fifo_avail)
    );

    tx_frame_fsm #(
        .SYNC_WORDS (SYNC_WORDS),
        .GAP_WORDS  (GAP_WORDS)
    ) u_tx_frame_fsm (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_mode         (mode),
        .i_start_flag   (start_flag),
        .i_stop_test    (i_stop_test),
        .i_cfg          (cfg),
        .i_word         (fifo_word),
        .i_word_avail   (fifo_avail),
        .o_word_take    (word_take),
        .o_frame_begun  (frame_begun),
        .o_line         (fsm_line),
        .o_kind         (kind),
        .o_sum_clear    (sum_clear),
        .o_tx_interrupt (o_tx_interrupt)
    );

    tx_line_encoder u_tx_line_encoder (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_line       (fsm_line),
        .i_kind       (kind),
        .i_sum_clear  (sum_clear),
        .o_line       (enc_line)
    );

    assign o_2711_txd   = enc_line.txd;
    assign o_2711_tkmsb = enc_line.tk_msb;
    assign o_2711_tklsb = enc_line.tk_lsb;

endmodule

// File: tx_line_encoder.sv
// checksum accumulator and registered TLK2711 line word
`timescale 1ns/1ps

module tx_line_encoder (
    input  logic                    clk,
    input  logic                    i_soft_reset,
    input  tlk_line_pkg::line_out_t i_line,
    input  tx_ctrl_pkg::word_kind_e i_kind,
    input  logic                    i_sum_clear,
    output tlk_line_pkg::line_out_t o_line
);

    // 16-bit wrap-around sum of frame number, length and payload
    tlk_line_pkg::line_word_t sum;

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            sum <= '0;
        end else if (i_sum_clear) begin
            sum <= '0;
        end else if (i_kind == tx_ctrl_pkg::WK_SUMMED) begin
            sum <= sum + i_line.txd;
        end
    end

    //////////////////////////////
    // output register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            // link sees commas straight after reset
            o_line <= tlk_line_pkg::COMMA_WORD;
        end else begin
            o_line <= i_line;
            if (i_kind == tx_ctrl_pkg::WK_SUM) begin
                o_line.txd <= sum;
            end
        end
    end

    // every checksum word belongs to a frame opened by SOF
    a_sum_after_sof: assert property (@(posedge clk) disable iff (i_soft_reset)
        i_sum_clear |-> i_line == tlk_line_pkg::SOF_WORD);

endmodule

// File: tx_frame_fsm.sv
// frame sequencer with word counters, frame index, test stop flag and interrupt timer
`timescale 1ns/1ps

module tx_frame_fsm #(
    parameter int SYNC_WORDS = 6,
    parameter int GAP_WORDS  = 16
) (
    input  logic                     clk,
    input  logic                     i_soft_reset,
    input  tx_ctrl_pkg::tx_mode_e    i_mode,
    input  logic                     i_start_flag,
    input  logic                     i_stop_test,
    input  tx_ctrl_pkg::frame_cfg_t  i_cfg,
    input  tlk_line_pkg::line_word_t i_word,
    input  logic                     i_word_avail,
    output logic                     o_word_take,
    output logic                     o_frame_begun,
    output tlk_line_pkg::line_out_t  o_line,
    output tx_ctrl_pkg::word_kind_e  o_kind,
    output logic                     o_sum_clear,
    output logic                     o_tx_interrupt
);

    tx_ctrl_pkg::frame_state_e state;
    tx_ctrl_pkg::frame_num_t   frame_idx;
    tx_ctrl_pkg::byte_len_t    frame_len;
    tlk_line_pkg::line_word_t  data_txd;
    // shared by sync, head, payload, gap and interrupt counting
    logic [15:0]               step_cnt;
    logic [15:0]               data_words;
    logic                      stop_pend;
    logic                      test_mode;
    logic                      last_frame;
    logic                      go;
    logic                      data_sel;
    logic                      word_step;

    assign test_mode  = (i_mode == tx_ctrl_pkg::MODE_TEST);
    assign last_frame = !test_mode && (frame_idx == i_cfg.body_num);
    assign frame_len  = last_frame ? i_cfg.tail_len : i_cfg.body_len;
    assign data_words = {1'b0, frame_len[15:1]};

    // normal mode waits for the first word in the FIFO
    assign go            = i_start_flag && (test_mode || i_word_avail);
    assign o_frame_begun = (state == tx_ctrl_pkg::ST_IDLE) && go;

    //////////////////////////////
    // word selection
    //////////////////////////////

    always_comb begin
        o_line      = tlk_line_pkg::COMMA_WORD;
        o_kind      = tx_ctrl_pkg::WK_FIXED;
        o_sum_clear = 1'b0;
        o_word_take = 1'b0;
        data_sel    = 1'b0;
        data_txd    = '0;
        word_step   = 1'b0;
        case (state)
            tx_ctrl_pkg::ST_SOF: begin
                o_line      = tlk_line_pkg::SOF_WORD;
                o_sum_clear = 1'b1;
            end
            tx_ctrl_pkg::ST_HEAD: begin
                data_sel = 1'b1;
                data_txd = step_cnt[0] ? tlk_line_pkg::HEAD_1 : tlk_line_pkg::HEAD_0;
            end
            tx_ctrl_pkg::ST_SIGN: begin
                data_sel = 1'b1;
                data_txd = (test_mode || last_frame) ? tlk_line_pkg::FILE_END_SIGN
                                                     : tlk_line_pkg::FILE_SIGN;
            end
            tx_ctrl_pkg::ST_NUM: begin
                data_sel = 1'b1;
                data_txd = frame_idx[15:0];
                o_kind   = tx_ctrl_pkg::WK_SUMMED;
            end
            tx_ctrl_pkg::ST_LEN: begin
                data_sel = 1'b1;
                data_txd = frame_len;
                o_kind   = tx_ctrl_pkg::WK_SUMMED;
            end
            tx_ctrl_pkg::ST_DATA: begin
                // test pattern is the payload word count itself
                // underrun leaves the comma in place
                word_step   = test_mode || i_word_avail;
                o_word_take = !test_mode && i_word_avail;
                data_sel    = word_step;
                data_txd    = test_mode ? step_cnt : i_word;
                if (word_step) begin
                    o_kind = tx_ctrl_pkg::WK_SUMMED;
                end
            end
            tx_ctrl_pkg::ST_SUM: begin
                data_sel = 1'b1;
                o_kind   = tx_ctrl_pkg::WK_SUM;
            end
            tx_ctrl_pkg::ST_EOF: begin
                o_line = tlk_line_pkg::EOF_WORD;
            end
            default: ;
        endcase
        if (data_sel) begin
            o_line = '{txd: data_txd, tk_msb: 1'b0, tk_lsb: 1'b0};
        end
    end

    //////////////////////////////
    // state walk and counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state          <= tx_ctrl_pkg::ST_IDLE;
            frame_idx      <= '0;
            step_cnt       <= '0;
            stop_pend      <= 1'b0;
            o_tx_interrupt <= 1'b0;
        end else begin
            if (i_stop_test && test_mode && state != tx_ctrl_pkg::ST_IDLE) begin
                stop_pend <= 1'b1;
            end
            case (state)
                tx_ctrl_pkg::ST_IDLE: begin
                    step_cnt  <= '0;
                    frame_idx <= '0;
                    if (go) begin
                        state <= tx_ctrl_pkg::ST_SYNC;
                    end
                end
                tx_ctrl_pkg::ST_SYNC: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == SYNC_WORDS - 1) begin
                        state <= tx_ctrl_pkg::ST_SOF;
                    end
                end
                tx_ctrl_pkg::ST_SOF: begin
                    step_cnt <= '0;
                    state    <= tx_ctrl_pkg::ST_HEAD;
                end
                tx_ctrl_pkg::ST_HEAD: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt[0]) begin
                        state <= tx_ctrl_pkg::ST_SIGN;
                    end
                end
                tx_ctrl_pkg::ST_SIGN: state <= tx_ctrl_pkg::ST_NUM;
                tx_ctrl_pkg::ST_NUM:  state <= tx_ctrl_pkg::ST_LEN;
                tx_ctrl_pkg::ST_LEN: begin
                    step_cnt <= '0;
                    state    <= (data_words == '0) ? tx_ctrl_pkg::ST_SUM : tx_ctrl_pkg::ST_DATA;
                end
                tx_ctrl_pkg::ST_DATA: begin
                    if (word_step) begin
                        step_cnt <= step_cnt + 1'b1;
                        if (step_cnt == data_words - 1'b1) begin
                            state <= tx_ctrl_pkg::ST_SUM;
                        end
                    end
                end
                tx_ctrl_pkg::ST_SUM: state <= tx_ctrl_pkg::ST_EOF;
                tx_ctrl_pkg::ST_EOF: begin
                    step_cnt <= '0;
                    state    <= tx_ctrl_pkg::ST_GAP;
                end
                tx_ctrl_pkg::ST_GAP: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == GAP_WORDS - 1) begin
                        step_cnt <= '0;
                        if (test_mode && (stop_pend || i_stop_test)) begin
                            stop_pend <= 1'b0;
                            state     <= tx_ctrl_pkg::ST_IDLE;
                        end else if (last_frame) begin
                            o_tx_interrupt <= (i_cfg.intr_width != '0);
                            state <= (i_cfg.intr_width != '0) ? tx_ctrl_pkg::ST_INTR
                                                              : tx_ctrl_pkg::ST_IDLE;
                        end else begin
                            frame_idx <= frame_idx + 1'b1;
                            state     <= tx_ctrl_pkg::ST_SOF;
                        end
                    end
                end
                tx_ctrl_pkg::ST_INTR: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == i_cfg.intr_width - 1'b1) begin
                        o_tx_interrupt <= 1'b0;
                        state          <= tx_ctrl_pkg::ST_IDLE;
                    end
                end
                default: state <= tx_ctrl_pkg::ST_IDLE;
            endcase
        end
    end

    // interrupt only at the end of a normal-mode file
    a_intr_state: assert property (@(posedge clk) disable iff (i_soft_reset)
        o_tx_interrupt |-> (state == tx_ctrl_pkg::ST_INTR) && !test_mode);

endmodule

// File: tx_word_fifo.sv
// DMA beat FIFO with first-word-fall-through 16-bit lane output
`timescale 1ns/1ps

module tx_word_fifo #(
    parameter int DMA_WIDTH  = 64,
    parameter int FIFO_BEATS = 64
) (
    input  logic                     clk,
    input  logic                     i_soft_reset,
    input  logic                     i_wr_valid,
    input  logic [DMA_WIDTH-1:0]     i_wr_data,
    output logic                     o_wr_ready,
    input  logic                     i_word_take,
    output tlk_line_pkg::line_word_t o_word,
    output logic                     o_word_avail
);

    // at least two lanes per beat
    localparam int LANES = DMA_WIDTH / 16;
    localparam int AW    = $clog2(FIFO_BEATS);
    localparam int LW    = $clog2(LANES);

    logic [DMA_WIDTH-1:0] mem [FIFO_BEATS];
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    logic [AW:0]          beat_cnt;
    logic [LW-1:0]        lane;
    logic                 push;
    logic                 take;
    logic                 pop;

    assign o_wr_ready   = (beat_cnt != (AW+1)'(FIFO_BEATS));
    assign o_word_avail = (beat_cnt != '0);

    assign push = i_wr_valid && o_wr_ready;
    assign take = i_word_take && o_word_avail;
    // beat is freed with its last lane
    assign pop  = take && (lane == LW'(LANES - 1));

    // lowest lane goes out first
    assign o_word = mem[rd_ptr][lane*16 +: 16];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    //////////////////////////////
    // pointers and fill level
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            beat_cnt <= '0;
            lane     <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_BEATS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_BEATS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (take) begin
                lane <= (lane == LW'(LANES - 1)) ? '0 : lane + 1'b1;
            end
            beat_cnt <= beat_cnt + (AW+1)'(push) - (AW+1)'(pop);
        end
    end

    // the sequencer only takes a word it was offered
    a_take_avail: assert property (@(posedge clk) disable iff (i_soft_reset)
        i_word_take |-> o_word_avail);

endmodule

// File: tx_ctrl_pkg.sv
// transmit mode and sequencer state enums, length and count types, frame configuration
package tx_ctrl_pkg;

    // normal sends the DMA payload, test sends a counting pattern
    typedef enum logic {MODE_NORM, MODE_TEST} tx_mode_e;

    typedef enum logic [3:0] {
        ST_IDLE, ST_SYNC, ST_SOF, ST_HEAD, ST_SIGN, ST_NUM,
        ST_LEN, ST_DATA, ST_SUM, ST_EOF, ST_GAP, ST_INTR
    } frame_state_e;

    // frame length in bytes, always a multiple of 8
    typedef logic [15:0] byte_len_t;

    // frame index within a file
    typedef logic [23:0] frame_num_t;

    // interrupt width in clock cycles
    typedef logic [15:0] intr_width_t;

    // transfer setup, held stable while a file is sent
    typedef struct packed {
        byte_len_t   body_len;
        byte_len_t   tail_len;
        frame_num_t  body_num;
        intr_width_t intr_width;
    } frame_cfg_t;

    // what the encoder does with the word of this cycle
    typedef enum logic [1:0] {
        WK_FIXED,
        WK_SUMMED,
        WK_SUM
    } word_kind_e;

endpackage

// File: tlk_line_pkg.sv
// serial link word type, line output struct, K-code words and frame header constants
package tlk_line_pkg;

    // one word on the TLK2711 TXD bus
    typedef logic [15:0] line_word_t;

    // word plus its two K flags, tk_msb covers the upper byte
    typedef struct packed {
        line_word_t txd;
        logic       tk_msb;
        logic       tk_lsb;
    } line_out_t;

    //////////////////////////////
    // K-code words
    //////////////////////////////

    // D5.6 over K28.5, only the low byte is a K code
    localparam line_out_t COMMA_WORD = '{txd: 16'hC5BC, tk_msb: 1'b0, tk_lsb: 1'b1};

    // start of frame, K28.2 over K27.7
    localparam line_out_t SOF_WORD   = '{txd: 16'h5CFB, tk_msb: 1'b1, tk_lsb: 1'b1};

    // end of frame, K29.7 over K30.7
    localparam line_out_t EOF_WORD   = '{txd: 16'hFDFE, tk_msb: 1'b1, tk_lsb: 1'b1};

    //////////////////////////////
    // frame header data words
    //////////////////////////////

    localparam line_word_t HEAD_0 = 16'hEB90;
    localparam line_word_t HEAD_1 = 16'hE116;

    // data type 0x81 in the upper byte, file end flag in the lower byte
    localparam line_word_t FILE_SIGN     = 16'h8100;
    localparam line_word_t FILE_END_SIGN = 16'h8101;

endpackage
